/* bench/ClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module ClockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    // reset held low over the first 8 rising edges
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/RetireTb.sv */
`timescale 1ns/1ps
`default_nettype none

module RetireTb import RetirePkg::*; ();

    logic clk;
    logic rstN;
    logic valid;
    logic [XLEN-1:0] pc;
    logic [31:0] insn;
    logic regWriteEnable;
    RegType dstRegType;
    logic [REG_ADDR_W-1:0] dstRegAddr;
    logic [XLEN-1:0] dstIntValue;
    logic [FLEN-1:0] dstFpValue;
    logic trapValid;
    logic [CAUSE_W-1:0] trapCause;
    logic [XLEN-1:0] trapValue;
    logic trapReturn;
    logic [REG_ADDR_W-1:0] intReadAddrA;
    logic [REG_ADDR_W-1:0] intReadAddrB;
    logic [XLEN-1:0] intReadDataA;
    logic [XLEN-1:0] intReadDataB;
    logic [REG_ADDR_W-1:0] fpReadAddrA;
    logic [REG_ADDR_W-1:0] fpReadAddrB;
    logic [FLEN-1:0] fpReadDataA;
    logic [FLEN-1:0] fpReadDataB;
    logic [CSR_SEL_W-1:0] csrReadAddr;
    logic [XLEN-1:0] csrReadData;
    logic redirectValid;
    logic [XLEN-1:0] redirectPc;

    // reference model of the architectural state
    logic [XLEN-1:0] modelInt [REG_COUNT];
    logic [FLEN-1:0] modelFp [REG_COUNT];
    logic [XLEN-1:0] modelMepc;
    logic [CAUSE_W-1:0] modelMcause;
    logic [XLEN-1:0] modelMtval;
    PrivLevel modelPriv;
    PrivLevel modelMpp;
    logic expRedirect;
    logic [XLEN-1:0] expRedirectPc;
    int seed;

    ClockGen clockGen (.clk, .rstN);

    RetireTop UUT (.*);

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // status word: priv in bits 1:0, MPP at the mstatus position
    function automatic logic [XLEN-1:0] expectedCsr(input logic [CSR_SEL_W-1:0] sel);
        logic [XLEN-1:0] status;
        status = '0;
        status[STATUS_MPP_LSB +: PRIV_W] = modelMpp;
        status[PRIV_W-1:0] = modelPriv;
        case (sel)
            CsrSelMepc:   return modelMepc;
            CsrSelMcause: return XLEN'(modelMcause);
            CsrSelMtval:  return modelMtval;
            default:      return status;
        endcase
    endfunction

    // sweep both files two entries per cycle, CSRs in rotation
    task automatic checkState();
        for (int i = 0; i < REG_COUNT / 2; i++) begin
            @(posedge clk);
            intReadAddrA <= REG_ADDR_W'(2 * i);
            intReadAddrB <= REG_ADDR_W'(2 * i + 1);
            fpReadAddrA <= REG_ADDR_W'(2 * i);
            fpReadAddrB <= REG_ADDR_W'(2 * i + 1);
            csrReadAddr <= CSR_SEL_W'(i);
            @(negedge clk);
            checkValue("intReadDataA", 64'(intReadDataA), 64'(modelInt[2 * i]));
            checkValue("intReadDataB", 64'(intReadDataB), 64'(modelInt[2 * i + 1]));
            checkValue("fpReadDataA", fpReadDataA, modelFp[2 * i]);
            checkValue("fpReadDataB", fpReadDataB, modelFp[2 * i + 1]);
            checkValue("csrReadData", 64'(csrReadData), 64'(expectedCsr(CSR_SEL_W'(i))));
        end
    endtask

    task automatic waitRedirect();
        int cycles;
        cycles = 0;
        while (!redirectValid && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!redirectValid) begin
            $display("redirectValid never came after a trap or mret");
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic issueSlot(input logic v, input logic wen, input RegType rt,
            input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] iv,
            input logic [FLEN-1:0] fv, input logic trap, input logic [CAUSE_W-1:0] cause,
            input logic [XLEN-1:0] tval, input logic [XLEN-1:0] slotPc, input logic ret);
        expRedirect = 1'b0;
        @(posedge clk);
        valid <= v;
        pc <= slotPc;
        insn <= ret ? 32'h3020_0073 : 32'h0000_0013;  // mret or nop
        regWriteEnable <= wen;
        dstRegType <= rt;
        dstRegAddr <= addr;
        dstIntValue <= iv;
        dstFpValue <= fv;
        trapValid <= trap;
        trapCause <= cause;
        trapValue <= tval;
        trapReturn <= ret;
        if (v && trap) begin            // trap entry, nothing written
            modelMepc = slotPc;
            modelMcause = cause;
            modelMtval = tval;
            modelMpp = modelPriv;
            modelPriv = PrivMachine;
            expRedirect = 1'b1;
            expRedirectPc = TRAP_VECTOR;
        end else if (v) begin
            if (wen && rt == RegTypeFp) modelFp[addr] = fv;
            else if (wen && addr != '0) modelInt[addr] = iv;
            if (ret) begin
                expRedirect = 1'b1;
                expRedirectPc = modelMepc;  // mepc before the return
                modelPriv = modelMpp;
                modelMpp = PrivUser;
            end
        end
        @(posedge clk);
        valid <= 1'b0;                  // other fields linger on purpose
        @(negedge clk);
        if (expRedirect) begin
            waitRedirect();
            checkValue("redirectPc", 64'(redirectPc), 64'(expRedirectPc));
        end else begin
            checkValue("redirectValid", 64'(redirectValid), 64'(0));
        end
        checkState();
    endtask

    task automatic randomSlot();
        logic [31:0] r;
        logic [31:0] iv;
        logic [31:0] slotPc;
        r = $random(seed);
        iv = $random(seed);
        slotPc = $random(seed);
        issueSlot(r[2:0] != 3'd0, r[3], RegType'(r[4]), r[9:5], iv,
            {iv ^ r, r}, r[11:10] == 2'd0, r[15:12], ~iv, {slotPc[31:2], 2'b00},
            r[17:16] == 2'd0);
    endtask

    initial begin
        int cycles;
        seed = 32'hf6ad3db4;
        valid = 1'b0;
        pc = '0;
        insn = '0;
        regWriteEnable = 1'b0;
        dstRegType = RegTypeInt;
        dstRegAddr = '0;
        dstIntValue = '0;
        dstFpValue = '0;
        trapValid = 1'b0;
        trapCause = '0;
        trapValue = '0;
        trapReturn = 1'b0;
        intReadAddrA = '0;
        intReadAddrB = '0;
        fpReadAddrA = '0;
        fpReadAddrB = '0;
        csrReadAddr = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            modelInt[i] = '0;
            modelFp[i] = '0;
        end
        modelMepc = '0;
        modelMcause = '0;
        modelMtval = '0;
        modelPriv = RESET_PRIV;
        modelMpp = PrivUser;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            $display("Test failures found");
            $fatal(1);
        end
        checkState();                   // reset values
        issueSlot(1, 1, RegTypeInt, 5, 32'hdead_beef, '0, 0, '0, '0, 32'h1000, 0);
        issueSlot(1, 1, RegTypeInt, 0, 32'h1111_2222, '0, 0, '0, '0, 32'h1004, 0);  // x0
        issueSlot(1, 1, RegTypeFp, 3, '0, 64'hc001_d00d_0bad_f00d, 0, '0, '0, 32'h1008, 0);
        issueSlot(1, 1, RegTypeFp, 0, '0, 64'h0123_4567_89ab_cdef, 0, '0, '0, 32'h100c, 0);
        // trap from machine mode with a write pending
        issueSlot(1, 1, RegTypeInt, 6, 32'h6666_6666, '0, 1, CauseIllegalInsn,
            32'hbad0_0001, 32'h1010, 0);
        issueSlot(1, 0, RegTypeInt, 0, '0, '0, 0, '0, '0, 32'h0104, 1);  // back to M
        issueSlot(1, 0, RegTypeInt, 0, '0, '0, 0, '0, '0, 32'h0108, 1);  // drop to U
        issueSlot(1, 1, RegTypeFp, 7, '0, 64'h7777, 1, CauseEcallUser, 32'h0, 32'h2000, 0);
        issueSlot(1, 0, RegTypeInt, 0, '0, '0, 0, '0, '0, 32'h0110, 1);  // mret to user
        // idle slots carrying write, trap and mret fields
        issueSlot(0, 1, RegTypeInt, 9, 32'h9999_9999, '0, 1, CauseBreakpoint,
            32'h9, 32'h3000, 1);
        issueSlot(0, 1, RegTypeFp, 9, '0, 64'h9999, 0, '0, '0, 32'h3004, 1);
        repeat (300) randomSlot();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/RetireTop_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module RetireTopProperties (
    input wire logic clk,
    input wire logic rstN,
    input wire logic valid,
    input wire logic trapValid,
    input wire logic trapReturn,
    input wire logic intWriteEnable,
    input wire logic fpWriteEnable,
    input wire logic redirectValid
);

    logic redirectCause;                // slot that must redirect fetch next cycle

    assign redirectCause = valid && (trapValid || trapReturn);

    // first cycle out of reset has no redirect pending
    resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> !redirectValid)
        else $error("redirectValid high right after reset");

    noTrapWrite: assert property (@(posedge clk) disable iff (!rstN)
        valid && trapValid |-> !intWriteEnable && !fpWriteEnable)
        else $error("register file written by a trapping slot");

    // redirect pulse lands exactly one cycle after the event
    redirectFollows: assert property (@(posedge clk) disable iff (!rstN)
        redirectCause |=> redirectValid)
        else $error("redirectValid missing one cycle after trap or mret");

    noStrayRedirect: assert property (@(posedge clk) disable iff (!rstN)
        !redirectCause |=> !redirectValid)
        else $error("redirectValid high without a trap or mret");

endmodule

bind RetireTop RetireTopProperties props (
    .clk(clk), .rstN(rstN), .valid(valid), .trapValid(trapValid), .trapReturn(trapReturn),
    .intWriteEnable(intWriteEnable), .fpWriteEnable(fpWriteEnable),
    .redirectValid(redirectValid)
);

`default_nettype wire

/* filelist.f */
source/RetirePkg.sv
source/ExecuteStageIf.sv
source/CsrIf.sv
source/RegWriteStage.sv
source/RegFile.sv
source/CsrTrapUnit.sv
source/RetireTop.sv
bench/ClockGen.sv
bench/RetireTop_properties.sv
bench/RetireTb.sv

/* run.sh */
#!/bin/sh
# build and run the retire stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module RetireTb -f filelist.f -o simv

# the log decides the result, not the simulator exit code
./obj_dir/simv | tee sim.log
grep -q "All tests passed!" sim.log

/* source/CsrIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface CsrIf import RetirePkg::*; ();

    // trap entry request
    logic trapValid;
    logic [CAUSE_W-1:0] trapCause;
    logic [XLEN-1:0] trapValue;         // goes to mtval
    logic [XLEN-1:0] trapPc;            // goes to mepc

    logic trapReturn;                   // committed mret

    modport RegWriteStage (
        output trapValid, trapCause, trapValue, trapPc, trapReturn
    );

    modport TrapUnit (
        input trapValid, trapCause, trapValue, trapPc, trapReturn
    );

endinterface

`default_nettype wire

/* source/CsrTrapUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module CsrTrapUnit import RetirePkg::*; (
    input wire logic clk,
    input wire logic rstN,

    CsrIf.TrapUnit csr,

    // observation port
    input wire logic [CSR_SEL_W-1:0] csrReadAddr,
    output logic [XLEN-1:0] csrReadData,

    // fetch redirect, one cycle after the trap or mret retires
    output logic redirectValid,
    output logic [XLEN-1:0] redirectPc
);

    // machine mode trap state
    PrivLevel priv;                     // current privilege
    PrivLevel mpp;                      // mstatus.MPP
    logic [XLEN-1:0] mepc;
    logic [CAUSE_W-1:0] mcause;
    logic [XLEN-1:0] mtval;

    logic takeTrap;
    logic takeReturn;
    logic [XLEN-1:0] statusWord;

    // trap entry has priority wherever both are looked at
    assign takeTrap = csr.trapValid;
    assign takeReturn = csr.trapReturn;

    // trap entry saves the context
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else if (takeTrap) begin
            mepc <= csr.trapPc;
            mcause <= csr.trapCause;
            mtval <= csr.trapValue;
        end
    end

    // privilege stack of depth one
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            priv <= RESET_PRIV;
            mpp <= PrivUser;
        end else if (takeTrap) begin
            mpp <= priv;                // remember where we came from
            priv <= PrivMachine;        // all traps handled in M mode
        end else if (takeReturn) begin
            priv <= mpp;
            mpp <= PrivUser;            // MPP drops to the least privileged mode
        end
    end

    // redirect register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            redirectValid <= 1'b0;
        end else begin
            redirectValid <= takeTrap || takeReturn;  // pulse, never held
        end
    end

    // target register, meaningful only while redirectValid is high
    always_ff @(posedge clk) begin
        if (takeTrap) begin
            redirectPc <= TRAP_VECTOR;
        end else if (takeReturn) begin
            redirectPc <= mepc;         // value before this edge
        end
    end

    // mstatus like view of priv and MPP
    always_comb begin
        statusWord = '0;
        statusWord[STATUS_MPP_LSB +: PRIV_W] = mpp;
        statusWord[PRIV_W-1:0] = priv;
    end

    always_comb begin
        case (csrReadAddr)
            CsrSelMepc:   csrReadData = mepc;
            CsrSelMcause: csrReadData = {{(XLEN - CAUSE_W){1'b0}}, mcause};  // interrupt bit stays 0
            CsrSelMtval:  csrReadData = mtval;
            CsrSelStatus: csrReadData = statusWord;
            default:      csrReadData = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/ExecuteStageIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ExecuteStageIf import RetirePkg::*; ();

    logic valid;                        // slot present this cycle
    logic [XLEN-1:0] pc;
    logic [31:0] insn;                  // raw encoding, kept for debug visibility

    // destination register
    logic regWriteEnable;
    RegType dstRegType;
    logic [REG_ADDR_W-1:0] dstRegAddr;
    logic [XLEN-1:0] dstIntValue;
    logic [FLEN-1:0] dstFpValue;

    // exception raised upstream
    logic trapValid;
    logic [CAUSE_W-1:0] trapCause;
    logic [XLEN-1:0] trapValue;
    logic trapReturn;                   // slot is an mret

    modport Driver (
        output valid, pc, insn,
        output regWriteEnable, dstRegType, dstRegAddr, dstIntValue, dstFpValue,
        output trapValid, trapCause, trapValue, trapReturn
    );

    modport NextStage (
        input valid, pc, insn,
        input regWriteEnable, dstRegType, dstRegAddr, dstIntValue, dstFpValue,
        input trapValid, trapCause, trapValue, trapReturn
    );

endinterface

`default_nettype wire

/* source/RegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module RegFile import RetirePkg::*; #(
    parameter int DATA_W = XLEN,
    parameter bit ZERO_HARDWIRED = 1'b1  // x0 style entry zero
) (
    input wire logic clk,
    input wire logic rstN,

    // write port
    input wire logic writeEnable,
    input wire logic [REG_ADDR_W-1:0] writeAddr,
    input wire logic [DATA_W-1:0] writeValue,

    // read ports, combinational
    input wire logic [REG_ADDR_W-1:0] readAddrA,
    input wire logic [REG_ADDR_W-1:0] readAddrB,
    output logic [DATA_W-1:0] readDataA,
    output logic [DATA_W-1:0] readDataB
);

    logic [DATA_W-1:0] entries [REG_COUNT];
    logic writeAllowed;

    // true when the addressed entry is the constant zero register
    function automatic logic isZeroReg(input logic [REG_ADDR_W-1:0] addr);
        return ZERO_HARDWIRED && addr == '0;
    endfunction

    assign writeAllowed = writeEnable && !isZeroReg(writeAddr);  // x0 swallows writes

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                entries[i] <= '0;       // architectural state starts at zero
            end
        end else if (writeAllowed) begin
            entries[writeAddr] <= writeValue;
        end
    end

    // new value visible right after the write edge, no bypass needed
    always_comb begin
        if (isZeroReg(readAddrA)) begin
            readDataA = '0;
        end else begin
            readDataA = entries[readAddrA];
        end

        if (isZeroReg(readAddrB)) begin
            readDataB = '0;
        end else begin
            readDataB = entries[readAddrB];
        end
    end

endmodule

`default_nettype wire

/* source/RegWriteStage.sv */
`timescale 1ns/1ps
`default_nettype none

module RegWriteStage import RetirePkg::*; (
    ExecuteStageIf.NextStage prevStage,
    CsrIf.RegWriteStage csr,

    output logic intWriteEnable,
    output logic [REG_ADDR_W-1:0] intWriteAddr,
    output logic [XLEN-1:0] intWriteValue,

    output logic fpWriteEnable,
    output logic [REG_ADDR_W-1:0] fpWriteAddr,
    output logic [FLEN-1:0] fpWriteValue
);

    logic valid;
    logic commit;                       // valid slot without exception
    logic writeReg;                     // committed slot with a destination

    // commit decision, the only place the slot is qualified
    always_comb begin
        valid = prevStage.valid;
        commit = valid && !prevStage.trapValid;
        writeReg = commit && prevStage.regWriteEnable;
    end

    // trap unit requests
    always_comb begin
        csr.trapValid = valid && prevStage.trapValid;
        csr.trapCause = prevStage.trapCause;
        csr.trapValue = prevStage.trapValue;
        csr.trapPc = prevStage.pc;      // faulting insn address for mepc
        // mret only takes effect when it retires cleanly
        csr.trapReturn = commit && prevStage.trapReturn;
    end

    // steer the result to one of the two files
    always_comb begin
        intWriteEnable = writeReg && prevStage.dstRegType == RegTypeInt;
        intWriteAddr = prevStage.dstRegAddr;
        intWriteValue = prevStage.dstIntValue;

        fpWriteEnable = writeReg && prevStage.dstRegType == RegTypeFp;
        fpWriteAddr = prevStage.dstRegAddr;
        fpWriteValue = prevStage.dstFpValue;  // no NaN boxing, full 64 bits stored
    end

endmodule

`default_nettype wire

/* source/RetirePkg.sv */
`default_nettype none

package RetirePkg;

    // datapath widths
    localparam int XLEN = 32;           // integer regs, pc, CSRs
    localparam int FLEN = 64;           // double precision FP regs
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT = 1 << REG_ADDR_W;  // 32 entries per file

    localparam int PRIV_W = 2;
    localparam int CAUSE_W = 4;         // exception codes only, no interrupts

    // privilege modes, RISC-V encoding (2 is reserved)
    typedef enum logic [PRIV_W-1:0] {
        PrivUser       = 2'd0,
        PrivSupervisor = 2'd1,
        PrivMachine    = 2'd3
    } PrivLevel;

    // destination register file of a slot
    typedef enum logic {
        RegTypeInt = 1'b0,
        RegTypeFp  = 1'b1
    } RegType;

    // synchronous exception codes as written to mcause
    localparam logic [CAUSE_W-1:0] CauseInsnMisaligned  = 4'd0;
    localparam logic [CAUSE_W-1:0] CauseInsnAccessFault = 4'd1;
    localparam logic [CAUSE_W-1:0] CauseIllegalInsn     = 4'd2;
    localparam logic [CAUSE_W-1:0] CauseBreakpoint      = 4'd3;
    localparam logic [CAUSE_W-1:0] CauseLoadMisaligned  = 4'd4;
    localparam logic [CAUSE_W-1:0] CauseLoadAccessFault = 4'd5;
    localparam logic [CAUSE_W-1:0] CauseStoreMisaligned = 4'd6;
    localparam logic [CAUSE_W-1:0] CauseStoreAccessFault = 4'd7;
    localparam logic [CAUSE_W-1:0] CauseEcallUser       = 4'd8;
    localparam logic [CAUSE_W-1:0] CauseEcallSupervisor = 4'd9;
    localparam logic [CAUSE_W-1:0] CauseEcallMachine    = 4'd11;

    // observation port select on the trap unit
    localparam int CSR_SEL_W = 2;
    localparam logic [CSR_SEL_W-1:0] CsrSelMepc   = 2'd0;
    localparam logic [CSR_SEL_W-1:0] CsrSelMcause = 2'd1;
    localparam logic [CSR_SEL_W-1:0] CsrSelMtval  = 2'd2;
    localparam logic [CSR_SEL_W-1:0] CsrSelStatus = 2'd3;  // priv and MPP

    // MPP sits where mstatus keeps it, current priv goes in bits 1:0
    localparam int STATUS_MPP_LSB = 11;

    localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100;  // fixed mtvec, direct mode
    localparam PrivLevel RESET_PRIV = PrivMachine;

endpackage

`default_nettype wire

/* source/RetireTop.sv */
`timescale 1ns/1ps
`default_nettype none

module RetireTop import RetirePkg::*; (
    input wire logic clk,
    input wire logic rstN,

    // execute slot
    input wire logic valid,
    input wire logic [XLEN-1:0] pc,
    input wire logic [31:0] insn,
    input wire logic regWriteEnable,
    input wire RegType dstRegType,
    input wire logic [REG_ADDR_W-1:0] dstRegAddr,
    input wire logic [XLEN-1:0] dstIntValue,
    input wire logic [FLEN-1:0] dstFpValue,
    input wire logic trapValid,
    input wire logic [CAUSE_W-1:0] trapCause,
    input wire logic [XLEN-1:0] trapValue,
    input wire logic trapReturn,

    // integer file observation
    input wire logic [REG_ADDR_W-1:0] intReadAddrA,
    input wire logic [REG_ADDR_W-1:0] intReadAddrB,
    output logic [XLEN-1:0] intReadDataA,
    output logic [XLEN-1:0] intReadDataB,

    // FP file observation
    input wire logic [REG_ADDR_W-1:0] fpReadAddrA,
    input wire logic [REG_ADDR_W-1:0] fpReadAddrB,
    output logic [FLEN-1:0] fpReadDataA,
    output logic [FLEN-1:0] fpReadDataB,

    input wire logic [CSR_SEL_W-1:0] csrReadAddr,
    output logic [XLEN-1:0] csrReadData,

    output logic redirectValid,
    output logic [XLEN-1:0] redirectPc
);

    ExecuteStageIf execSlot();
    CsrIf csrReq();

    logic intWriteEnable;
    logic [REG_ADDR_W-1:0] intWriteAddr;
    logic [XLEN-1:0] intWriteValue;
    logic fpWriteEnable;
    logic [REG_ADDR_W-1:0] fpWriteAddr;
    logic [FLEN-1:0] fpWriteValue;

    // driver side of the slot, straight from the pins
    assign execSlot.valid = valid;
    assign execSlot.pc = pc;
    assign execSlot.insn = insn;
    assign execSlot.regWriteEnable = regWriteEnable;
    assign execSlot.dstRegType = dstRegType;
    assign execSlot.dstRegAddr = dstRegAddr;
    assign execSlot.dstIntValue = dstIntValue;
    assign execSlot.dstFpValue = dstFpValue;
    assign execSlot.trapValid = trapValid;
    assign execSlot.trapCause = trapCause;
    assign execSlot.trapValue = trapValue;
    assign execSlot.trapReturn = trapReturn;

    RegWriteStage regWriteStage (
        .prevStage(execSlot.NextStage), .csr(csrReq.RegWriteStage),
        .intWriteEnable, .intWriteAddr, .intWriteValue,
        .fpWriteEnable, .fpWriteAddr, .fpWriteValue
    );

    RegFile #(.DATA_W(XLEN), .ZERO_HARDWIRED(1'b1)) intRegFile (  // x0 reads zero
        .clk, .rstN,
        .writeEnable(intWriteEnable), .writeAddr(intWriteAddr), .writeValue(intWriteValue),
        .readAddrA(intReadAddrA), .readAddrB(intReadAddrB),
        .readDataA(intReadDataA), .readDataB(intReadDataB)
    );

    RegFile #(.DATA_W(FLEN), .ZERO_HARDWIRED(1'b0)) fpRegFile (   // f0 is a real register
        .clk, .rstN,
        .writeEnable(fpWriteEnable), .writeAddr(fpWriteAddr), .writeValue(fpWriteValue),
        .readAddrA(fpReadAddrA), .readAddrB(fpReadAddrB),
        .readDataA(fpReadDataA), .readDataB(fpReadDataB)
    );

    CsrTrapUnit csrTrapUnit (
        .clk, .rstN, .csr(csrReq.TrapUnit),
        .csrReadAddr, .csrReadData, .redirectValid, .redirectPc
    );

endmodule

`default_nettype wire
